// ==== rtl/dadda_mul_cfg.svh ====
// width macros for operands, half operands, tiles and the quarter count
`ifndef DADDA_MUL_CFG_SVH
`define DADDA_MUL_CFG_SVH

// full operand width of the multiplier
`define DADDA_OP_W      32

// half operand, one 16 by 16 lane
`define DADDA_HALF_W    16

// leaf tile operand width
`define DADDA_TILE_W    8

// quarter products per level
`define DADDA_QUARTERS  4

`endif

// ==== rtl/dadda_mul_pkg.sv ====
// operand, quarter and product types plus full adder and half adder bit functions
`default_nettype none

`include "dadda_mul_cfg.svh"

package dadda_mul_pkg;

    typedef logic [`DADDA_OP_W-1:0]     op_t;
    typedef logic [`DADDA_HALF_W-1:0]   half_t;
    typedef logic [2*`DADDA_HALF_W-1:0] quarter_t;

    // index order is low by low, low by high, high by low, high by high
    typedef quarter_t [`DADDA_QUARTERS-1:0] quarter_arr_t;

    typedef logic [2*`DADDA_OP_W-1:0] product_t;

    function automatic logic fa_sum(input logic x, input logic y, input logic z);
        return x ^ y ^ z;
    endfunction

    // majority of the three inputs
    function automatic logic fa_carry(input logic x, input logic y, input logic z);
        return (x & y) | (x & z) | (y & z);
    endfunction

    function automatic logic ha_sum(input logic x, input logic y);
        return x ^ y;
    endfunction

    function automatic logic ha_carry(input logic x, input logic y);
        return x & y;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/dadda_8.sv ====
// 8 by 8 dadda tile with partial products, four reduction stages and a final ripple adder
`default_nettype none

`include "dadda_mul_cfg.svh"

module dadda_8
    import dadda_mul_pkg::*;
(
    input  logic [`DADDA_TILE_W-1:0]   a,
    input  logic [`DADDA_TILE_W-1:0]   b,
    output logic [2*`DADDA_TILE_W-1:0] y
);

    // pp[i][j] is a[j] and b[i] with weight i + j
    logic [`DADDA_TILE_W-1:0][`DADDA_TILE_W-1:0] pp;

    // sums and carries of the stages 8 to 6, 6 to 4, 4 to 3 and 3 to 2
    logic [5:0]  s1, c1;
    logic [13:0] s2, c2;
    logic [9:0]  s3, c3;
    logic [11:0] s4, c4;

    // two rows left for the final adder
    logic [14:0] row_a;
    logic [14:1] row_b;
    logic [15:2] rc;

    // carry in the upper bit and sum in the lower
    function automatic logic [1:0] fa3(input logic p, input logic q, input logic r);
        return {fa_carry(p, q, r), fa_sum(p, q, r)};
    endfunction

    function automatic logic [1:0] ha2(input logic p, input logic q);
        return {ha_carry(p, q), ha_sum(p, q)};
    endfunction

    always_comb begin
        for (int i = 0; i < `DADDA_TILE_W; i++) begin
            for (int j = 0; j < `DADDA_TILE_W; j++) begin
                pp[i][j] = a[j] & b[i];
            end
        end
    end

    // height 8 to 6 over columns 6 to 9
    assign {c1[0], s1[0]} = ha2(pp[6][0], pp[5][1]);
    assign {c1[1], s1[1]} = fa3(pp[7][0], pp[6][1], pp[5][2]);
    assign {c1[2], s1[2]} = ha2(pp[4][3], pp[3][4]);
    assign {c1[3], s1[3]} = fa3(pp[7][1], pp[6][2], pp[5][3]);
    assign {c1[4], s1[4]} = ha2(pp[4][4], pp[3][5]);
    assign {c1[5], s1[5]} = fa3(pp[7][2], pp[6][3], pp[5][4]);

    // height 6 to 4 over columns 4 to 11
    assign {c2[0], s2[0]}   = ha2(pp[4][0], pp[3][1]);
    assign {c2[1], s2[1]}   = fa3(pp[5][0], pp[4][1], pp[3][2]);
    assign {c2[2], s2[2]}   = ha2(pp[2][3], pp[1][4]);
    assign {c2[3], s2[3]}   = fa3(s1[0], pp[4][2], pp[3][3]);
    assign {c2[4], s2[4]}   = fa3(pp[2][4], pp[1][5], pp[0][6]);
    assign {c2[5], s2[5]}   = fa3(s1[1], s1[2], c1[0]);
    assign {c2[6], s2[6]}   = fa3(pp[2][5], pp[1][6], pp[0][7]);
    assign {c2[7], s2[7]}   = fa3(s1[3], s1[4], c1[1]);
    assign {c2[8], s2[8]}   = fa3(c1[2], pp[2][6], pp[1][7]);
    assign {c2[9], s2[9]}   = fa3(s1[5], c1[3], c1[4]);
    assign {c2[10], s2[10]} = fa3(pp[4][5], pp[3][6], pp[2][7]);
    assign {c2[11], s2[11]} = fa3(pp[7][3], pp[6][4], c1[5]);
    assign {c2[12], s2[12]} = fa3(pp[5][5], pp[4][6], pp[3][7]);
    assign {c2[13], s2[13]} = fa3(pp[7][4], pp[6][5], pp[5][6]);

    // height 4 to 3 over columns 3 to 12
    assign {c3[0], s3[0]} = ha2(pp[3][0], pp[2][1]);
    assign {c3[1], s3[1]} = fa3(s2[0], pp[2][2], pp[1][3]);
    assign {c3[2], s3[2]} = fa3(s2[1], s2[2], c2[0]);
    assign {c3[3], s3[3]} = fa3(s2[3], c2[1], c2[2]);
    assign {c3[4], s3[4]} = fa3(s2[5], c2[3], c2[4]);
    assign {c3[5], s3[5]} = fa3(s2[7], c2[5], c2[6]);
    assign {c3[6], s3[6]} = fa3(s2[9], c2[7], c2[8]);
    assign {c3[7], s3[7]} = fa3(s2[11], c2[9], c2[10]);
    assign {c3[8], s3[8]} = fa3(s2[13], c2[11], c2[12]);
    assign {c3[9], s3[9]} = fa3(pp[7][5], pp[6][6], pp[5][7]);

    // height 3 to 2 over columns 2 to 13
    assign {c4[0], s4[0]}   = ha2(pp[2][0], pp[1][1]);
    assign {c4[1], s4[1]}   = fa3(s3[0], pp[1][2], pp[0][3]);
    assign {c4[2], s4[2]}   = fa3(s3[1], c3[0], pp[0][4]);
    assign {c4[3], s4[3]}   = fa3(s3[2], c3[1], pp[0][5]);
    assign {c4[4], s4[4]}   = fa3(s3[3], c3[2], s2[4]);
    assign {c4[5], s4[5]}   = fa3(s3[4], c3[3], s2[6]);
    assign {c4[6], s4[6]}   = fa3(s3[5], c3[4], s2[8]);
    assign {c4[7], s4[7]}   = fa3(s3[6], c3[5], s2[10]);
    assign {c4[8], s4[8]}   = fa3(s3[7], c3[6], s2[12]);
    assign {c4[9], s4[9]}   = fa3(s3[8], c3[7], pp[4][7]);
    assign {c4[10], s4[10]} = fa3(s3[9], c3[8], c2[13]);
    assign {c4[11], s4[11]} = fa3(pp[7][6], pp[6][7], c3[9]);

    // column k of both rows has weight k
    assign row_a = {pp[7][7], s4, pp[1][0], pp[0][0]};
    assign row_b = {c4, pp[0][2], pp[0][1]};

    // column 0 holds a single bit and column 1 only two
    assign y[0]  = row_a[0];
    assign y[1]  = ha_sum(row_a[1], row_b[1]);
    assign rc[2] = ha_carry(row_a[1], row_b[1]);

    for (genvar k = 2; k < 15; k++) begin : g_ripple
        assign y[k]    = fa_sum(row_a[k], row_b[k], rc[k]);
        assign rc[k+1] = fa_carry(row_a[k], row_b[k], rc[k]);
    end

    // top column holds only the last carry
    assign y[15] = rc[15];

endmodule

`default_nettype wire

// ==== rtl/quarter_combiner.sv ====
// quarter product combiner with one 3-to-2 row and a ripple adder
`default_nettype none

module quarter_combiner
    import dadda_mul_pkg::*;
#(
    parameter int half_w = 16
) (
    input  logic [2*half_w-1:0] q0,
    input  logic [2*half_w-1:0] q1,
    input  logic [2*half_w-1:0] q2,
    input  logic [2*half_w-1:0] q3,
    output logic [4*half_w-1:0] y
);

    // third csa row, q0 upper half below q3 lower half
    logic [2*half_w-1:0] row_x;

    // csa column j has weight half_w + j
    logic [2*half_w-1:0] s;
    logic [2*half_w-1:0] c;

    // rc[j] is the carry into column j of the ripple
    logic [3*half_w:2] rc;

    assign row_x = {q3[half_w-1:0], q0[2*half_w-1:half_w]};

    for (genvar j = 0; j < 2*half_w; j++) begin : g_csa
        assign s[j] = fa_sum(row_x[j], q1[j], q2[j]);
        assign c[j] = fa_carry(row_x[j], q1[j], q2[j]);
    end

    // low half of q0 has nothing to add
    assign y[half_w-1:0] = q0[half_w-1:0];
    assign y[half_w]     = s[0];
    assign y[half_w+1]   = ha_sum(s[1], c[0]);
    assign rc[2]         = ha_carry(s[1], c[0]);

    for (genvar j = 2; j < 2*half_w; j++) begin : g_ripple
        assign y[half_w+j] = fa_sum(s[j], c[j-1], rc[j]);
        assign rc[j+1]     = fa_carry(s[j], c[j-1], rc[j]);
    end

    // last csa carry meets the first q3 bit above the csa row
    assign y[3*half_w]    = fa_sum(q3[half_w], c[2*half_w-1], rc[2*half_w]);
    assign rc[2*half_w+1] = fa_carry(q3[half_w], c[2*half_w-1], rc[2*half_w]);

    // remaining q3 bits only take the carry
    for (genvar j = 2*half_w + 1; j < 3*half_w; j++) begin : g_tail
        assign y[half_w+j] = ha_sum(q3[j-half_w], rc[j]);
        assign rc[j+1]     = ha_carry(q3[j-half_w], rc[j]);
    end

    // quarters of a real product never overflow 4*half_w bits
    always_comb begin
        a_no_carry_out: assert final (rc[3*half_w] == 1'b0)
            else $error("quarter combiner carry out of the top column");
    end

endmodule

`default_nettype wire

// ==== rtl/dadda_16.sv ====
// 16 by 16 multiplier from four dadda tiles and a quarter combiner
`default_nettype none

`include "dadda_mul_cfg.svh"

module dadda_16
    import dadda_mul_pkg::*;
(
    input  half_t    a,
    input  half_t    b,
    output quarter_t y
);

    logic [`DADDA_TILE_W-1:0] a_lo;
    logic [`DADDA_TILE_W-1:0] a_hi;
    logic [`DADDA_TILE_W-1:0] b_lo;
    logic [`DADDA_TILE_W-1:0] b_hi;

    // tile products, same quarter order as the top level
    logic [2*`DADDA_TILE_W-1:0] p_ll;
    logic [2*`DADDA_TILE_W-1:0] p_lh;
    logic [2*`DADDA_TILE_W-1:0] p_hl;
    logic [2*`DADDA_TILE_W-1:0] p_hh;

    assign a_lo = a[`DADDA_TILE_W-1:0];
    assign a_hi = a[2*`DADDA_TILE_W-1:`DADDA_TILE_W];
    assign b_lo = b[`DADDA_TILE_W-1:0];
    assign b_hi = b[2*`DADDA_TILE_W-1:`DADDA_TILE_W];

    dadda_8 tile_ll (.a(a_lo), .b(b_lo), .y(p_ll));
    dadda_8 tile_lh (.a(a_lo), .b(b_hi), .y(p_lh));
    dadda_8 tile_hl (.a(a_hi), .b(b_lo), .y(p_hl));
    dadda_8 tile_hh (.a(a_hi), .b(b_hi), .y(p_hh));

    quarter_combiner #(
        .half_w(`DADDA_TILE_W)
    ) comb_i (
        .q0(p_ll),
        .q1(p_lh),
        .q2(p_hl),
        .q3(p_hh),
        .y (y)
    );

endmodule

`default_nettype wire

// ==== rtl/product_assembler.sv ====
// quarter product registers and the final combiner for the 64-bit product
`default_nettype none

`include "dadda_mul_cfg.svh"

module product_assembler
    import dadda_mul_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  quarter_arr_t quarters,
    output product_t     y
);

    // the only pipeline stage of the multiplier
    quarter_arr_t quarters_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            quarters_q <= '0;
        end else begin
            quarters_q <= quarters;
        end
    end

    // y follows the registers with no further delay
    quarter_combiner #(
        .half_w(`DADDA_HALF_W)
    ) comb_i (
        .q0(quarters_q[0]),
        .q1(quarters_q[1]),
        .q2(quarters_q[2]),
        .q3(quarters_q[3]),
        .y (y)
    );

    // lanes upstream must deliver fully known quarters every cycle
    a_quarters_known: assert property (
        @(posedge clk) disable iff (!arst_n) !$isunknown(quarters_q)
    ) else $error("unknown bits in registered quarter products");

endmodule

`default_nettype wire

// ==== rtl/dadda_mul_top.sv ====
// 32 by 32 dadda multiplier top with four 16 by 16 lanes and the product assembler
`default_nettype none

`include "dadda_mul_cfg.svh"

module dadda_mul_top
    import dadda_mul_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  op_t      a,
    input  op_t      b,
    output product_t y
);

    // index 0 is the low half, 1 the high half
    half_t [1:0] a_half;
    half_t [1:0] b_half;

    quarter_arr_t quarters;

    assign a_half = a;
    assign b_half = b;

    // lane q takes a half q/2 and b half q%2
    for (genvar q = 0; q < `DADDA_QUARTERS; q++) begin : g_lane
        dadda_16 mul_i (
            .a(a_half[q/2]),
            .b(b_half[q%2]),
            .y(quarters[q])
        );
    end

    product_assembler asm_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .quarters(quarters),
        .y       (y)
    );

endmodule

`default_nettype wire

// ==== dv/dadda_mul_vectors.svh ====
// directed operand pairs, expected products and test names for the multiplier testbench
`ifndef DADDA_MUL_VECTORS_SVH
`define DADDA_MUL_VECTORS_SVH

// each entry holds operand a, operand b and the expected product
typedef struct packed {
    op_t      a;
    op_t      b;
    product_t y;
} vector_t;

localparam int NUM_VECTORS = 18;

localparam vector_t VECTORS [NUM_VECTORS] = '{
    '{32'h0000_0000, 32'h0000_0000, 64'h0000_0000_0000_0000},
    '{32'h0000_0000, 32'hffff_ffff, 64'h0000_0000_0000_0000},
    '{32'h0000_0001, 32'h0000_0001, 64'h0000_0000_0000_0001},
    '{32'h0000_0001, 32'hffff_ffff, 64'h0000_0000_ffff_ffff},
    '{32'hffff_ffff, 32'hffff_ffff, 64'hffff_fffe_0000_0001},
    '{32'h8000_0000, 32'h8000_0000, 64'h4000_0000_0000_0000},
    '{32'h0001_0000, 32'h0001_0000, 64'h0000_0001_0000_0000},
    '{32'h0000_0100, 32'h0100_0000, 64'h0000_0001_0000_0000},
    '{32'h0000_ffff, 32'h0000_ffff, 64'h0000_0000_fffe_0001},
    '{32'hffff_0000, 32'hffff_0000, 64'hfffe_0001_0000_0000},
    '{32'h0000_ffff, 32'hffff_0000, 64'h0000_fffe_0001_0000},
    '{32'h0000_00ff, 32'h0000_00ff, 64'h0000_0000_0000_fe01},
    '{32'h0000_ff00, 32'h0000_00ff, 64'h0000_0000_00fe_0100},
    '{32'hffff_ffff, 32'h0001_0001, 64'h0001_0000_fffe_ffff},
    '{32'hffff_ffff, 32'h8000_0001, 64'h8000_0000_7fff_ffff},
    '{32'h5555_5555, 32'h0000_0003, 64'h0000_0000_ffff_ffff},
    '{32'hffff_ffff, 32'h0000_0002, 64'h0000_0001_ffff_fffe},
    '{32'h0001_0000, 32'hffff_ffff, 64'h0000_ffff_ffff_0000}
};

// names in the same order as the table
string vector_names [NUM_VECTORS] = '{
    "zero_by_zero",
    "zero_by_ones",
    "one_by_one",
    "one_by_ones",
    "ones_by_ones",
    "pow2_31_by_pow2_31",
    "pow2_16_by_pow2_16",
    "pow2_8_by_pow2_24",
    "low_half_only",
    "high_half_only",
    "low_half_by_high_half",
    "tile_carry",
    "tile_cross",
    "quarter_carry",
    "top_bit_carry",
    "alternating_by_three",
    "ones_by_two",
    "pow2_16_by_ones"
};

`endif

// ==== dv/dadda_mul_tb.sv ====
// testbench for the 32 by 32 dadda multiplier with directed table, random and reset checks
`default_nettype none

module dadda_mul_tb
    import dadda_mul_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_RANDOM   = 200;
    localparam int HOLD_CYCLES  = 4;

    `include "dadda_mul_vectors.svh"

    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_VECTORS + NUM_RANDOM + 20;

    logic     clk;
    logic     arst_n;
    op_t      a;
    op_t      b;
    product_t y;

    // expectation for the pair driven on the previous cycle
    string    prev_name;
    product_t prev_exp;

    logic [31:0] lfsr_state;

    dadda_mul_top dut_i (
        .clk   (clk),
        .arst_n(arst_n),
        .a     (a),
        .b     (b),
        .y     (y)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the test sequence did not finish in the expected time");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic random_word(output op_t w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_product(input string name, input product_t expected,
                                 input product_t actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "product check failed");
        end
    endtask

    // y still holds last cycle's product when the new pair goes in
    task automatic apply_pair(input string name, input op_t na, input op_t nb);
        @(posedge clk);
        #DRIVE_DELAY;
        check_product(prev_name, prev_exp, y);
        a = na;
        b = nb;
        prev_name = name;
        prev_exp = product_t'(na) * product_t'(nb);
    endtask

    task automatic check_last;
        @(posedge clk);
        #DRIVE_DELAY;
        check_product(prev_name, prev_exp, y);
    endtask

    initial begin
        op_t ra;
        op_t rb;

        arst_n = 1'b0;
        a = 32'hffff_ffff;
        b = 32'h8765_4321;
        lfsr_state = 32'h1df6_48b9;

        // nonzero operands while reset is held
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            check_product("reset_hold", '0, y);
        end
        arst_n = 1'b1;

        // operands stay in place but no edge has sampled them yet
        @(negedge clk);
        check_product("reset_release", '0, y);
        prev_name = "first_sample";
        prev_exp = product_t'(a) * product_t'(b);

        for (int i = 0; i < NUM_VECTORS; i++) begin
            apply_pair(vector_names[i], VECTORS[i].a, VECTORS[i].b);
            // table value replaces the model value
            prev_exp = VECTORS[i].y;
        end

        // one new pair every cycle
        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_word(ra);
            random_word(rb);
            apply_pair($sformatf("random_%0d", i), ra, rb);
        end

        random_word(ra);
        random_word(rb);
        repeat (HOLD_CYCLES) begin
            apply_pair("held_operands", ra, rb);
        end

        check_last();
        arst_n = 1'b0;
        #1;
        check_product("mid_reset_async", '0, y);
        @(posedge clk);
        #DRIVE_DELAY;
        check_product("mid_reset_held", '0, y);

        random_word(ra);
        random_word(rb);
        arst_n = 1'b1;
        a = ra;
        b = rb;
        prev_name = "after_reset_first";
        prev_exp = product_t'(ra) * product_t'(rb);

        random_word(ra);
        random_word(rb);
        apply_pair("after_reset_second", ra, rb);
        check_last();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dadda_mul.f ====
+incdir+rtl
+incdir+dv
rtl/dadda_mul_pkg.sv
rtl/dadda_8.sv
rtl/quarter_combiner.sv
rtl/dadda_16.sv
rtl/product_assembler.sv
rtl/dadda_mul_top.sv
dv/dadda_mul_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the dadda multiplier testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=dadda_mul_sim
LOG_FILE=sim.log

verilator --binary --timing --assert \
    -f dadda_mul.f \
    --top-module dadda_mul_tb \
    -Mdir "${BUILD_DIR}" \
    -o "${SIM_BIN}"
build_status=$?
if [ ${build_status} -ne 0 ]; then
    echo "build failed with status ${build_status}"
    exit 1
fi

"./${BUILD_DIR}/${SIM_BIN}" > "${LOG_FILE}" 2>&1
run_status=$?
cat "${LOG_FILE}"

if grep -q "STATUS: FAIL" "${LOG_FILE}"; then
    echo "simulation reported failure"
    exit 1
fi
if [ ${run_status} -ne 0 ]; then
    echo "simulation exited with status ${run_status}"
    exit 1
fi
echo "simulation finished without failure"
exit 0
